/* dbg_trigger.f */
+incdir+.
dbg_trigger_csr_pkg.sv
dbg_trigger_mem_pkg.sv
dbg_trigger_csr_bank.sv
dbg_trigger_match_exec.sv
dbg_trigger_match_mem.sv
dbg_trigger_top.sv
dbg_trigger_clk_gen.sv
dbg_trigger_asserts.sv
dbg_trigger_tb.sv

/* dbg_trigger_asserts.sv */
`timescale 1ns/1ps
`include "dbg_trigger_defs.svh"

module dbg_trigger_asserts (
  input logic                          clk_i,
  input logic                          rst_n,
  input logic                          retire_valid,
  input dbg_trigger_mem_pkg::retire_t  retire,
  input logic                          match_valid,
  input logic [`DBG_NUM_TRIGGERS-1:0]  match
);

  // Number of property failures seen so far
  int failures = 0;

  // Every retirement produces exactly one result on the next cycle
  a_valid_follows: assert property (@(posedge clk_i) disable iff (!rst_n)
    retire_valid |=> match_valid)
    else begin
      failures++;
      $error("match_valid missing one cycle after retire_valid");
    end

  a_no_spurious_valid: assert property (@(posedge clk_i) disable iff (!rst_n)
    !retire_valid |=> !match_valid)
    else begin
      failures++;
      $error("match_valid raised without a retirement");
    end

  a_match_qualified: assert property (@(posedge clk_i) disable iff (!rst_n)
    !match_valid |-> (match == '0))
    else begin
      failures++;
      $error("match is nonzero while match_valid is low");
    end

  // A trapping instruction reports no trigger at all
  a_exception_quiet: assert property (@(posedge clk_i) disable iff (!rst_n)
    (retire_valid && retire.exception) |=> (match == '0))
    else begin
      failures++;
      $error("match reported for a retirement with an exception");
    end

endmodule

bind dbg_trigger_top dbg_trigger_asserts asserts_i (
  .clk_i        (clk_i),
  .rst_n        (rst_n),
  .retire_valid (retire_valid),
  .retire       (retire),
  .match_valid  (match_valid),
  .match        (match)
);

/* dbg_trigger_clk_gen.sv */
`timescale 1ns/1ps

module dbg_trigger_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset is held over two rising edges and released just after the second
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

/* dbg_trigger_csr_bank.sv */
`timescale 1ns/1ps
`include "dbg_trigger_defs.svh"

module dbg_trigger_csr_bank (
  input  logic                           clk_i,
  input  logic                           rst_n,
  input  logic                           csr_wr_valid,
  input  dbg_trigger_csr_pkg::csr_wr_t   csr_wr,
  output dbg_trigger_csr_pkg::tdata1_t   tdata1_arr [`DBG_NUM_TRIGGERS],
  output logic [31:0]                    tdata2_arr [`DBG_NUM_TRIGGERS],
  output logic [`DBG_NUM_TRIGGERS-1:0]   enable
);

  import dbg_trigger_csr_pkg::*;

  tdata1_t     tdata1_q [`DBG_NUM_TRIGGERS];
  logic [31:0] tdata2_q [`DBG_NUM_TRIGGERS];
  logic        wr_tdata1;
  logic        wr_tdata2;

  // Decode which of the two words the strobe addresses
  assign wr_tdata1 = csr_wr_valid && !csr_wr.sel_tdata2;
  assign wr_tdata2 = csr_wr_valid && csr_wr.sel_tdata2;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      for (int t = 0; t < `DBG_NUM_TRIGGERS; t++) begin
        tdata1_q[t] <= `DBG_TDATA1_RESET;
        tdata2_q[t] <= 32'h0;
      end
    end else begin
      if (wr_tdata1) begin
        tdata1_q[csr_wr.idx] <= csr_wr.data;
      end
      if (wr_tdata2) begin
        tdata2_q[csr_wr.idx] <= csr_wr.data;
      end
    end
  end

  for (genvar t = 0; t < `DBG_NUM_TRIGGERS; t++) begin : g_trig
    assign tdata1_arr[t] = tdata1_q[t];
    assign tdata2_arr[t] = tdata2_q[t];

    // Only mcontrol6 triggers armed for machine mode take part in matching
    assign enable[t] = (tdata1_q[t].gen.ttype == `DBG_TYPE_MCONTROL6) &&
                       tdata1_q[t].mc6.m;
  end

endmodule

/* dbg_trigger_csr_pkg.sv */
`include "dbg_trigger_defs.svh"

package dbg_trigger_csr_pkg;

  localparam int TRIG_IDX_W = $clog2(`DBG_NUM_TRIGGERS);

  // Header fields common to every trigger type
  typedef struct packed {
    logic [3:0]  ttype;
    logic        dmode;
    logic [26:0] data;
  } tdata1_generic_t;

  // Address and data match layout, type 6
  typedef struct packed {
    logic [3:0]  ttype;
    logic        dmode;
    logic [15:0] rsvd_26_11;
    logic [3:0]  match;
    logic        m;
    logic [2:0]  rsvd_5_3;
    logic        execute;
    logic        store;
    logic        load;
  } tdata1_mc6_t;

  // The same tdata1 word seen through either layout
  typedef union packed {
    tdata1_generic_t gen;
    tdata1_mc6_t     mc6;
  } tdata1_t;

  // One strobed write into the trigger CSR bank
  typedef struct packed {
    logic [TRIG_IDX_W-1:0] idx;
    logic                  sel_tdata2;
    logic [31:0]           data;
  } csr_wr_t;

endpackage

/* dbg_trigger_defs.svh */
`ifndef DBG_TRIGGER_DEFS_SVH
`define DBG_TRIGGER_DEFS_SVH

// Number of address triggers implemented in the debug module
`define DBG_NUM_TRIGGERS 4
// Push and pop style instructions retire with several memory accesses
`define DBG_MAX_MEM_OPS 4

`define DBG_TYPE_MCONTROL6 4'd6

// Match mode codes of the mcontrol6 match field
`define DBG_MATCH_EQ 4'd0
`define DBG_MATCH_GE 4'd2
`define DBG_MATCH_LT 4'd3

// Type 15 marks a trigger that exists but is disabled
`define DBG_TDATA1_RESET 32'hF000_0000

`endif

/* dbg_trigger_match_exec.sv */
`timescale 1ns/1ps
`include "dbg_trigger_defs.svh"

module dbg_trigger_match_exec (
  input  dbg_trigger_csr_pkg::tdata1_t  tdata1_arr [`DBG_NUM_TRIGGERS],
  input  logic [31:0]                   tdata2_arr [`DBG_NUM_TRIGGERS],
  input  logic [`DBG_NUM_TRIGGERS-1:0]  enable,
  input  logic [31:0]                   pc,
  input  logic                          exception,
  output logic [`DBG_NUM_TRIGGERS-1:0]  exec_match
);

  for (genvar t = 0; t < `DBG_NUM_TRIGGERS; t++) begin : g_trig
    logic pc_hit;

    always_comb begin
      case (tdata1_arr[t].mc6.match)
        `DBG_MATCH_EQ: pc_hit = (pc == tdata2_arr[t]);
        `DBG_MATCH_GE: pc_hit = (pc >= tdata2_arr[t]);
        `DBG_MATCH_LT: pc_hit = (pc < tdata2_arr[t]);
        // Mask and unsupported modes never fire
        default:       pc_hit = 1'b0;
      endcase
    end

    // A trapping instruction does not raise an execute trigger
    assign exec_match[t] = !exception && enable[t] &&
                           tdata1_arr[t].mc6.execute && pc_hit;
  end

endmodule

/* dbg_trigger_match_mem.sv */
`timescale 1ns/1ps
`include "dbg_trigger_defs.svh"

module dbg_trigger_match_mem #(
  parameter int OP_NR = 0
) (
  input  dbg_trigger_csr_pkg::tdata1_t  tdata1_arr [`DBG_NUM_TRIGGERS],
  input  logic [31:0]                   tdata2_arr [`DBG_NUM_TRIGGERS],
  input  logic [`DBG_NUM_TRIGGERS-1:0]  enable,
  input  logic [`DBG_NUM_TRIGGERS-1:0]  trigger_match_execute,
  input  dbg_trigger_mem_pkg::retire_t  retire,
  output logic [`DBG_NUM_TRIGGERS-1:0]  trigger_match_mem
);

  import dbg_trigger_mem_pkg::*;

  mem_op_t                              op;
  logic                                 access_ok;
  logic [3:0][31:0]                     byte_addr;
  logic [3:0]                           in_word0;
  logic [3:0][`DBG_NUM_TRIGGERS-1:0]    byte_match;
  logic [`DBG_NUM_TRIGGERS-1:0]         group_match;
  logic [`DBG_NUM_TRIGGERS-1:0]         any_match;

  assign op = retire.mem_ops[OP_NR];

  // Memory triggers lose to an exception and to any execute trigger
  assign access_ok = !retire.exception && !(|trigger_match_execute);

  for (genvar b = 0; b < 4; b++) begin : g_byte
    assign byte_addr[b] = op.addr + 32'(b);

    // Byte 0 always falls in its own word; later bytes may spill over
    assign in_word0[b] = (byte_addr[b][31:2] == byte_addr[0][31:2]);

    for (genvar t = 0; t < `DBG_NUM_TRIGGERS; t++) begin : g_trig
      logic dir_hit;
      logic addr_hit;

      assign dir_hit = (tdata1_arr[t].mc6.load && op.rmask[b]) ||
                       (tdata1_arr[t].mc6.store && op.wmask[b]);

      always_comb begin
        case (tdata1_arr[t].mc6.match)
          `DBG_MATCH_EQ: addr_hit = (byte_addr[b] == tdata2_arr[t]);
          `DBG_MATCH_GE: addr_hit = (byte_addr[b] >= tdata2_arr[t]);
          `DBG_MATCH_LT: addr_hit = (byte_addr[b] < tdata2_arr[t]);
          default:       addr_hit = 1'b0;
        endcase
      end

      assign byte_match[b][t] = access_ok && enable[t] && dir_hit && addr_hit;
    end
  end

  // When bytes in the first word match, the core reports only those.
  // Otherwise the hits from the spilled word are reported
  always_comb begin
    group_match = '0;
    any_match   = '0;
    for (int b = 0; b < 4; b++) begin
      any_match = any_match | byte_match[b];
      if (in_word0[b]) begin
        group_match = group_match | byte_match[b];
      end
    end
    trigger_match_mem = (|group_match) ? group_match : any_match;
  end

endmodule

/* dbg_trigger_mem_pkg.sv */
`include "dbg_trigger_defs.svh"

package dbg_trigger_mem_pkg;

  // One memory access of a retiring instruction
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
  } mem_op_t;

  // Everything the trigger logic needs to know about a retirement
  typedef struct packed {
    logic [31:0]                        pc;
    logic                               exception;
    mem_op_t [`DBG_MAX_MEM_OPS-1:0]     mem_ops;
  } retire_t;

  // Unused operation slots carry empty masks
  localparam mem_op_t MEM_OP_IDLE = '{addr: 32'h0, rmask: 4'h0, wmask: 4'h0};

endpackage

/* dbg_trigger_tb.sv */
`timescale 1ns/1ps
`include "dbg_trigger_defs.svh"

module dbg_trigger_tb;

  import dbg_trigger_csr_pkg::*;
  import dbg_trigger_mem_pkg::*;

  localparam int NT = `DBG_NUM_TRIGGERS;
  // About 20 CSR writes and 65 retirements, with ample margin
  localparam int CYCLE_LIMIT = 600;

  logic          clk;
  logic          rst_n;
  logic          csr_wr_valid;
  csr_wr_t       csr_wr;
  logic          retire_valid;
  retire_t       retire;
  logic          match_valid;
  logic [NT-1:0] match;

  // Shadow copy of the trigger CSRs as the testbench has written them
  logic [31:0]   model_t1 [NT];
  logic [31:0]   model_t2 [NT];
  logic [NT-1:0] exp_q [$];
  int            errors;
  int            checks;
  int            cycles;
  integer        seed;

  dbg_trigger_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  dbg_trigger_top dut_i (
    .clk_i        (clk),
    .rst_n        (rst_n),
    .csr_wr_valid (csr_wr_valid),
    .csr_wr       (csr_wr),
    .retire_valid (retire_valid),
    .retire       (retire),
    .match_valid  (match_valid),
    .match        (match)
  );

  function automatic logic [31:0] mc6_word(input logic [3:0] mode, input logic exe,
                                           input logic st, input logic ld);
    return {`DBG_TYPE_MCONTROL6, 1'b0, 16'h0, mode, 1'b1, 3'b0, exe, st, ld};
  endfunction

  function automatic logic trig_enabled(input int t);
    return (model_t1[t][31:28] == 4'd6) && model_t1[t][6];
  endfunction

  function automatic logic mode_hit(input int t, input logic [31:0] a);
    case (model_t1[t][10:7])
      `DBG_MATCH_EQ: return a == model_t2[t];
      `DBG_MATCH_GE: return a >= model_t2[t];
      `DBG_MATCH_LT: return a < model_t2[t];
      default:       return 1'b0;
    endcase
  endfunction

  // Expected trigger vector for one retirement under the current CSR model
  function automatic logic [NT-1:0] ref_match(input retire_t r);
    logic [NT-1:0] ex;
    logic [NT-1:0] mem_all;
    logic [NT-1:0] grp;
    logic [NT-1:0] all_bytes;
    logic [31:0]   a;
    logic          dir;
    ex = '0;
    mem_all = '0;
    for (int t = 0; t < NT; t++) begin
      if (!r.exception && trig_enabled(t) && model_t1[t][2] && mode_hit(t, r.pc)) begin
        ex[t] = 1'b1;
      end
    end
    if (ex != '0) return ex;
    if (r.exception) return '0;
    for (int k = 0; k < `DBG_MAX_MEM_OPS; k++) begin
      grp = '0;
      all_bytes = '0;
      for (int b = 0; b < 4; b++) begin
        a = r.mem_ops[k].addr + 32'(b);
        for (int t = 0; t < NT; t++) begin
          dir = (model_t1[t][0] && r.mem_ops[k].rmask[b]) ||
                (model_t1[t][1] && r.mem_ops[k].wmask[b]);
          if (trig_enabled(t) && dir && mode_hit(t, a)) begin
            all_bytes[t] = 1'b1;
            if (a[31:2] == r.mem_ops[k].addr[31:2]) grp[t] = 1'b1;
          end
        end
      end
      mem_all = mem_all | ((grp != '0) ? grp : all_bytes);
    end
    return mem_all;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    csr_wr_valid = 1'b0;
    retire_valid = 1'b0;
  endtask

  task automatic write_csr(input int idx, input logic sel2, input logic [31:0] data);
    @(posedge clk);
    #1;
    retire_valid = 1'b0;
    csr_wr_valid = 1'b1;
    csr_wr = '{idx: TRIG_IDX_W'(idx), sel_tdata2: sel2, data: data};
    if (sel2) model_t2[idx] = data;
    else model_t1[idx] = data;
  endtask

  task automatic program_trigger(input int idx, input logic [31:0] t1, input logic [31:0] t2);
    write_csr(idx, 1'b1, t2);
    write_csr(idx, 1'b0, t1);
  endtask

  task automatic retire_rec(input retire_t r);
    @(posedge clk);
    #1;
    csr_wr_valid = 1'b0;
    retire_valid = 1'b1;
    retire = r;
    exp_q.push_back(ref_match(r));
  endtask

  task automatic retire_access(input logic [31:0] pc, input logic exc, input logic [31:0] addr,
                               input logic [3:0] rmask, input logic [3:0] wmask);
    retire_t r;
    r.pc = pc;
    r.exception = exc;
    for (int k = 0; k < `DBG_MAX_MEM_OPS; k++) r.mem_ops[k] = MEM_OP_IDLE;
    r.mem_ops[0] = '{addr: addr, rmask: rmask, wmask: wmask};
    retire_rec(r);
  endtask

  task automatic random_retirements(input int count);
    retire_t r;
    repeat (count) begin
      r.pc = 32'h0000_8000 + 32'h100 * 32'($random(seed) & 15);
      r.exception = (($random(seed) & 15) == 0);
      for (int k = 0; k < `DBG_MAX_MEM_OPS; k++) begin
        r.mem_ops[k].addr  = 32'h4000_0000 + 32'($random(seed) & 7);
        r.mem_ops[k].rmask = 4'($random(seed));
        r.mem_ops[k].wmask = 4'($random(seed));
      end
      retire_rec(r);
    end
  endtask

  // Results are compared in the middle of the cycle, away from the clock edge
  always @(negedge clk) begin
    if (rst_n && match_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR at %0t ns: match_valid came with no retirement pending", $time);
      end else begin
        check_value("match", 32'(match), 32'(exp_q.pop_front()));
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: run stopped after %0d cycles without finishing the tests", cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    seed = 81;
    errors = 0;
    checks = 0;
    csr_wr_valid = 1'b0;
    csr_wr = '0;
    retire_valid = 1'b0;
    retire = '0;
    for (int t = 0; t < NT; t++) begin
      model_t1[t] = `DBG_TDATA1_RESET;
      model_t2[t] = 32'h0;
    end
    wait (rst_n === 1'b1);

    // All triggers are disabled straight after reset
    retire_access(32'h0000_8000, 1'b0, 32'h1000_0010, 4'hF, 4'h0);
    retire_access(32'h0000_8004, 1'b0, 32'h0000_0000, 4'h0, 4'hF);
    retire_access(32'h0000_0000, 1'b0, 32'h2000_0000, 4'hF, 4'hF);

    program_trigger(0, mc6_word(`DBG_MATCH_EQ, 1'b0, 1'b0, 1'b1), 32'h1000_0010);
    program_trigger(1, mc6_word(`DBG_MATCH_EQ, 1'b0, 1'b1, 1'b0), 32'h1000_0020);
    retire_access(32'h0000_8000, 1'b0, 32'h1000_0010, 4'hF, 4'h0);
    retire_access(32'h0000_8000, 1'b0, 32'h1000_0010, 4'h0, 4'hF);
    retire_access(32'h0000_8000, 1'b0, 32'h1000_000C, 4'hF, 4'h0);
    retire_access(32'h0000_8000, 1'b0, 32'h1000_0010, 4'h2, 4'h0);
    retire_access(32'h0000_8000, 1'b0, 32'h1000_000E, 4'hC, 4'h0);
    retire_access(32'h0000_8000, 1'b0, 32'h1000_0020, 4'h0, 4'h1);
    retire_access(32'h0000_8000, 1'b0, 32'h1000_001F, 4'h0, 4'h2);

    // Range modes on both sides of the limit
    program_trigger(2, mc6_word(`DBG_MATCH_GE, 1'b0, 1'b1, 1'b1), 32'h2000_0000);
    program_trigger(3, mc6_word(`DBG_MATCH_LT, 1'b0, 1'b1, 1'b0), 32'h0000_1000);
    retire_access(32'h0000_8000, 1'b0, 32'h1FFF_FFF0, 4'hF, 4'h0);
    retire_access(32'h0000_8000, 1'b0, 32'h2000_0000, 4'hF, 4'h0);
    retire_access(32'h0000_8000, 1'b0, 32'h1FFF_FFFE, 4'hC, 4'h0);
    retire_access(32'h0000_8000, 1'b0, 32'h0000_0FFC, 4'h0, 4'hF);
    retire_access(32'h0000_8000, 1'b0, 32'h0000_1000, 4'h0, 4'hF);
    retire_access(32'h0000_8000, 1'b0, 32'h3000_0000, 4'h0, 4'h3);

    // Word-group rule on accesses that spill into the next word
    write_csr(2, 1'b0, `DBG_TDATA1_RESET);
    write_csr(3, 1'b0, `DBG_TDATA1_RESET);
    program_trigger(0, mc6_word(`DBG_MATCH_EQ, 1'b0, 1'b0, 1'b1), 32'h4000_0003);
    program_trigger(1, mc6_word(`DBG_MATCH_EQ, 1'b0, 1'b1, 1'b1), 32'h4000_0004);
    retire_access(32'h0000_8000, 1'b0, 32'h4000_0002, 4'hF, 4'h0);
    retire_access(32'h0000_8000, 1'b0, 32'h4000_0002, 4'hC, 4'h0);
    retire_access(32'h0000_8000, 1'b0, 32'h4000_0001, 4'hF, 4'h0);
    retire_access(32'h0000_8000, 1'b0, 32'h4000_0004, 4'h0, 4'h1);

    // Execute triggers win over memory hits, exceptions silence everything
    program_trigger(3, mc6_word(`DBG_MATCH_EQ, 1'b1, 1'b0, 1'b0), 32'h0000_8000);
    program_trigger(2, mc6_word(`DBG_MATCH_GE, 1'b1, 1'b0, 1'b0), 32'h0000_9000);
    retire_access(32'h0000_8000, 1'b0, 32'h4000_0003, 4'h1, 4'h0);
    retire_access(32'h0000_8004, 1'b0, 32'h4000_0003, 4'h1, 4'h0);
    retire_access(32'h0000_9004, 1'b0, 32'h4000_0004, 4'h1, 4'h0);
    retire_access(32'h0000_8000, 1'b1, 32'h4000_0003, 4'h1, 4'h0);
    retire_access(32'h0000_8004, 1'b1, 32'h4000_0003, 4'h1, 4'h0);

    random_retirements(40);

    idle_cycle();
    while (exp_q.size() != 0) idle_cycle();
    errors += dut_i.asserts_i.failures;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* dbg_trigger_top.sv */
`timescale 1ns/1ps
`include "dbg_trigger_defs.svh"

module dbg_trigger_top (
  input  logic                           clk_i,
  input  logic                           rst_n,
  input  logic                           csr_wr_valid,
  input  dbg_trigger_csr_pkg::csr_wr_t   csr_wr,
  input  logic                           retire_valid,
  input  dbg_trigger_mem_pkg::retire_t   retire,
  output logic                           match_valid,
  output logic [`DBG_NUM_TRIGGERS-1:0]   match
);

  logic [31:0]                  tdata1_arr [`DBG_NUM_TRIGGERS];
  logic [31:0]                  tdata2_arr [`DBG_NUM_TRIGGERS];
  logic [`DBG_NUM_TRIGGERS-1:0] enable;
  logic [`DBG_NUM_TRIGGERS-1:0] exec_match;
  logic [`DBG_NUM_TRIGGERS-1:0] mem_match [`DBG_MAX_MEM_OPS];
  logic [`DBG_NUM_TRIGGERS-1:0] mem_match_any;
  logic [`DBG_NUM_TRIGGERS-1:0] match_d;

  dbg_trigger_csr_bank csr_bank_i (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .csr_wr_valid (csr_wr_valid),
    .csr_wr       (csr_wr),
    .tdata1_arr   (tdata1_arr),
    .tdata2_arr   (tdata2_arr),
    .enable       (enable)
  );

  dbg_trigger_match_exec match_exec_i (
    .tdata1_arr (tdata1_arr),
    .tdata2_arr (tdata2_arr),
    .enable     (enable),
    .pc         (retire.pc),
    .exception  (retire.exception),
    .exec_match (exec_match)
  );

  for (genvar k = 0; k < `DBG_MAX_MEM_OPS; k++) begin : g_mem_op
    dbg_trigger_match_mem #(
      .OP_NR (k)
    ) match_mem_i (
      .tdata1_arr            (tdata1_arr),
      .tdata2_arr            (tdata2_arr),
      .enable                (enable),
      .trigger_match_execute (exec_match),
      .retire                (retire),
      .trigger_match_mem     (mem_match[k])
    );
  end

  // Execute hits take priority over anything the accesses report
  always_comb begin
    mem_match_any = '0;
    for (int k = 0; k < `DBG_MAX_MEM_OPS; k++) begin
      mem_match_any = mem_match_any | mem_match[k];
    end
    match_d = (|exec_match) ? exec_match : mem_match_any;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      match_valid <= 1'b0;
      match       <= '0;
    end else begin
      match_valid <= retire_valid;
      match       <= retire_valid ? match_d : '0;
    end
  end

endmodule
